/* rtl/foc_pkg.sv */
`default_nettype none

package foc_pkg;

    // Raw SPI payload
    typedef logic [15:0] word_t;
    typedef logic [7:0] opcode_t;

    // Controller quantities
    typedef logic signed [15:0] curr_t;
    typedef logic signed [15:0] gain_t;

    // Full turn is 65536
    typedef logic [15:0] angle_t;

    // PWM period and duty in clk_sys cycles
    typedef logic [15:0] period_t;

    localparam opcode_t OP_GAINS = 8'h00;
    localparam opcode_t OP_SAMPLE = 8'hff;

    typedef enum logic [3:0] {
        IDLE,
        GAIN_KP,
        GAIN_KI,
        GAIN_PERIOD,
        SMP_MEAS,
        SMP_TARGET,
        SMP_ANGLE,
        WAIT_CTRL
    } cmd_state_t;

endpackage

`default_nettype wire

/* rtl/foc_sample_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface foc_sample_if;

    logic start;
    logic integ_clr;
    foc_pkg::curr_t curr_meas;
    foc_pkg::curr_t curr_target;
    foc_pkg::gain_t kp;
    foc_pkg::gain_t ki;
    foc_pkg::period_t period;

    modport cmd (
        output start, integ_clr, curr_meas, curr_target, kp, ki, period
    );

    modport ctrl (
        input start, integ_clr, curr_meas, curr_target, kp, ki, period
    );

endinterface

`default_nettype wire

/* rtl/spi_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_frame_rx (
    input  logic             clk_sys,
    input  logic             rstb,
    input  logic             spi_sclk,
    input  logic             spi_cs_n,
    input  logic             spi_mosi,
    output logic             op_push,
    output foc_pkg::opcode_t op_data,
    output logic             word_push,
    output foc_pkg::word_t   word_data
);

    logic [1:0] sclk_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sclk_d;
    logic       sclk_rise;
    logic       cs_active;
    logic [3:0] bit_cnt;
    logic       in_word;
    logic [14:0] shreg;

    ////////////////////
    // Pin synchronizers
    ////////////////////
    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            sclk_sync <= 2'b00;
            cs_sync   <= 2'b11;
            mosi_sync <= 2'b00;
            sclk_d    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            cs_sync   <= {cs_sync[0], spi_cs_n};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sclk_d    <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_d;
    assign cs_active = ~cs_sync[1];

    ////////////////////
    // Bit counting
    ////////////////////
    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            bit_cnt   <= 4'd0;
            in_word   <= 1'b0;
            op_push   <= 1'b0;
            word_push <= 1'b0;
        end else begin
            op_push   <= 1'b0;
            word_push <= 1'b0;
            if (!cs_active) begin
                // Partial fields are dropped here
                bit_cnt <= 4'd0;
                in_word <= 1'b0;
            end else if (sclk_rise) begin
                if (!in_word && bit_cnt == 4'd7) begin
                    op_push <= 1'b1;
                    in_word <= 1'b1;
                    bit_cnt <= 4'd0;
                end else if (in_word && bit_cnt == 4'd15) begin
                    word_push <= 1'b1;
                    bit_cnt   <= 4'd0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // MSB first shift path
    always_ff @(posedge clk_sys) begin
        if (cs_active && sclk_rise) begin
            shreg <= {shreg[13:0], mosi_sync[1]};
            if (!in_word && bit_cnt == 4'd7) begin
                op_data <= {shreg[6:0], mosi_sync[1]};
            end
            if (in_word && bit_cnt == 4'd15) begin
                word_data <= {shreg[14:0], mosi_sync[1]};
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int unsigned WIDTH      = 8,
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic             clk_sys,
    input  logic             rstb,
    input  logic             push,
    input  logic [WIDTH-1:0] wdata,
    input  logic             pop,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int unsigned ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W  = $clog2(FIFO_DEPTH + 1);

    logic [WIDTH-1:0]  mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Head entry is visible while not empty
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/foc_cmd_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module foc_cmd_fsm (
    input  logic               clk_sys,
    input  logic               rstb,
    input  logic               op_empty,
    input  foc_pkg::opcode_t   op_data,
    input  logic               word_empty,
    input  foc_pkg::word_t     word_data,
    input  logic               done,
    output logic               op_pop,
    output logic               word_pop,
    output foc_pkg::angle_t    angle,
    output logic               ready,
    foc_sample_if.cmd          smp
);

    foc_pkg::cmd_state_t state;
    logic                in_data;

    // Data states consume one word each
    always_comb begin
        case (state)
            foc_pkg::GAIN_KP,
            foc_pkg::GAIN_KI,
            foc_pkg::GAIN_PERIOD,
            foc_pkg::SMP_MEAS,
            foc_pkg::SMP_TARGET,
            foc_pkg::SMP_ANGLE: in_data = 1'b1;
            default:            in_data = 1'b0;
        endcase
    end

    assign op_pop   = (state == foc_pkg::IDLE) & ~op_empty;
    assign word_pop = in_data & ~word_empty;

    ////////////////////
    // Frame unpacking
    ////////////////////
    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            state           <= foc_pkg::IDLE;
            ready           <= 1'b1;
            angle           <= '0;
            smp.start       <= 1'b0;
            smp.integ_clr   <= 1'b0;
            smp.curr_meas   <= '0;
            smp.curr_target <= '0;
            smp.kp          <= '0;
            smp.ki          <= '0;
            smp.period      <= '0;
        end else begin
            smp.start     <= 1'b0;
            smp.integ_clr <= 1'b0;
            case (state)
                foc_pkg::IDLE: begin
                    if (!op_empty) begin
                        if (op_data == foc_pkg::OP_GAINS) begin
                            state <= foc_pkg::GAIN_KP;
                        end else if (op_data == foc_pkg::OP_SAMPLE) begin
                            ready <= 1'b0;
                            state <= foc_pkg::SMP_MEAS;
                        end
                    end
                end
                foc_pkg::GAIN_KP: begin
                    if (!word_empty) begin
                        smp.kp <= word_data;
                        state  <= foc_pkg::GAIN_KI;
                    end
                end
                foc_pkg::GAIN_KI: begin
                    if (!word_empty) begin
                        smp.ki <= word_data;
                        state  <= foc_pkg::GAIN_PERIOD;
                    end
                end
                foc_pkg::GAIN_PERIOD: begin
                    if (!word_empty) begin
                        smp.period    <= word_data;
                        // New gains restart the integrator
                        smp.integ_clr <= 1'b1;
                        state         <= foc_pkg::IDLE;
                    end
                end
                foc_pkg::SMP_MEAS: begin
                    if (!word_empty) begin
                        smp.curr_meas <= word_data;
                        state         <= foc_pkg::SMP_TARGET;
                    end
                end
                foc_pkg::SMP_TARGET: begin
                    if (!word_empty) begin
                        smp.curr_target <= word_data;
                        state           <= foc_pkg::SMP_ANGLE;
                    end
                end
                foc_pkg::SMP_ANGLE: begin
                    if (!word_empty) begin
                        angle     <= word_data;
                        smp.start <= 1'b1;
                        state     <= foc_pkg::WAIT_CTRL;
                    end
                end
                foc_pkg::WAIT_CTRL: begin
                    if (done) begin
                        ready <= 1'b1;
                        state <= foc_pkg::IDLE;
                    end
                end
                default: begin
                    ready <= 1'b1;
                    state <= foc_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/pi_current_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_current_ctrl #(
    parameter int unsigned Q_BITS = 8
) (
    input  logic              clk_sys,
    input  logic              rstb,
    foc_sample_if.ctrl        smp,
    output foc_pkg::period_t  duty,
    output logic              done
);

    logic signed [16:0] err_d;
    logic signed [17:0] integ_sum;
    foc_pkg::curr_t     integ_next;
    logic signed [16:0] err_q;
    foc_pkg::curr_t     integ_q;
    logic               valid_q;
    logic signed [32:0] prod_p;
    logic signed [31:0] prod_i;
    logic signed [33:0] acc;
    logic signed [33:0] scaled;
    logic signed [33:0] period_ext;
    foc_pkg::period_t   duty_next;

    ////////////////////
    // Stage 1
    ////////////////////
    assign err_d     = smp.curr_target - smp.curr_meas;
    assign integ_sum = integ_q + err_d;

    always_comb begin
        if (integ_sum > 18'sd32767) begin
            integ_next = 16'sh7fff;
        end else if (integ_sum < -18'sd32768) begin
            integ_next = 16'sh8000;
        end else begin
            integ_next = integ_sum[15:0];
        end
    end

    ////////////////////
    // Stage 2
    ////////////////////
    assign prod_p     = smp.kp * err_q;
    assign prod_i     = smp.ki * integ_q;
    assign acc        = prod_p + prod_i;
    assign scaled     = acc >>> Q_BITS;
    assign period_ext = $signed({18'd0, smp.period});

    // Duty stays inside one PWM period
    always_comb begin
        if (scaled < 34'sd0) begin
            duty_next = '0;
        end else if (scaled > period_ext) begin
            duty_next = smp.period;
        end else begin
            duty_next = scaled[15:0];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (smp.start) begin
            err_q <= err_d;
        end
    end

    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            integ_q <= '0;
            valid_q <= 1'b0;
            duty    <= '0;
            done    <= 1'b0;
        end else begin
            valid_q <= smp.start;
            done    <= valid_q;
            if (smp.integ_clr) begin
                integ_q <= '0;
            end else if (smp.start) begin
                integ_q <= integ_next;
            end
            if (valid_q) begin
                duty <= duty_next;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pwm_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_timer (
    input  logic             clk_sys,
    input  logic             rstb,
    input  foc_pkg::period_t period,
    input  foc_pkg::period_t duty,
    input  foc_pkg::angle_t  angle,
    input  logic             load,
    output logic             pwm_a,
    output logic             pwm_b,
    output logic             pwm_c
);

    foc_pkg::period_t cnt;
    foc_pkg::period_t pend_period;
    foc_pkg::period_t pend_duty;
    logic [2:0]       pend_sel;
    logic             pend_valid;
    foc_pkg::period_t sh_period;
    foc_pkg::period_t sh_duty;
    logic [2:0]       sh_sel;
    logic [2:0]       angle_sel;
    logic             idle;
    logic             wrap;
    logic             active;

    // One-hot phase from the angle, thirds of a turn
    always_comb begin
        if (angle < 16'd21845) begin
            angle_sel = 3'b001;
        end else if (angle < 16'd43690) begin
            angle_sel = 3'b010;
        end else begin
            angle_sel = 3'b100;
        end
    end

    assign idle = (sh_period == '0);
    assign wrap = ~idle & (cnt == sh_period - 16'd1);

    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            cnt         <= '0;
            pend_period <= '0;
            pend_duty   <= '0;
            pend_sel    <= 3'b000;
            pend_valid  <= 1'b0;
            sh_period   <= '0;
            sh_duty     <= '0;
            sh_sel      <= 3'b000;
        end else begin
            if (idle || wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 16'd1;
            end
            // Shadow update only at a period boundary
            if ((idle || wrap) && pend_valid) begin
                sh_period  <= pend_period;
                sh_duty    <= pend_duty;
                sh_sel     <= pend_sel;
                pend_valid <= 1'b0;
            end
            if (load) begin
                pend_period <= period;
                pend_duty   <= duty;
                pend_sel    <= angle_sel;
                pend_valid  <= 1'b1;
            end
        end
    end

    assign active = (cnt < sh_duty);
    assign pwm_a  = sh_sel[0] & active;
    assign pwm_b  = sh_sel[1] & active;
    assign pwm_c  = sh_sel[2] & active;

endmodule

`default_nettype wire

/* rtl/foc_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module foc_ctrl_top #(
    parameter int unsigned Q_BITS     = 8,
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic clk_sys,
    input  logic rstb,
    input  logic spi_sclk,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic full_spi,
    output logic pwm_a,
    output logic pwm_b,
    output logic pwm_c,
    output logic ready
);

    logic             op_push;
    foc_pkg::opcode_t op_wdata;
    logic             word_push;
    foc_pkg::word_t   word_wdata;
    logic             op_pop;
    foc_pkg::opcode_t op_rdata;
    logic             op_full;
    logic             op_empty;
    logic             word_pop;
    foc_pkg::word_t   word_rdata;
    logic             word_full;
    logic             word_empty;
    foc_pkg::angle_t  angle;
    foc_pkg::period_t duty;
    logic             done;

    foc_sample_if i_smp ();

    assign full_spi = op_full | word_full;

    ////////////////////
    // SPI ingress
    ////////////////////
    spi_frame_rx i_spi_frame_rx (
        .clk_sys   (clk_sys),
        .rstb      (rstb),
        .spi_sclk  (spi_sclk),
        .spi_cs_n  (spi_cs_n),
        .spi_mosi  (spi_mosi),
        .op_push   (op_push),
        .op_data   (op_wdata),
        .word_push (word_push),
        .word_data (word_wdata)
    );

    sync_fifo #(.WIDTH(8), .FIFO_DEPTH(FIFO_DEPTH)) i_op_fifo (
        .clk_sys (clk_sys),
        .rstb    (rstb),
        .push    (op_push),
        .wdata   (op_wdata),
        .pop     (op_pop),
        .rdata   (op_rdata),
        .full    (op_full),
        .empty   (op_empty)
    );

    sync_fifo #(.WIDTH(16), .FIFO_DEPTH(FIFO_DEPTH)) i_word_fifo (
        .clk_sys (clk_sys),
        .rstb    (rstb),
        .push    (word_push),
        .wdata   (word_wdata),
        .pop     (word_pop),
        .rdata   (word_rdata),
        .full    (word_full),
        .empty   (word_empty)
    );

    ////////////////////
    // Control path
    ////////////////////
    foc_cmd_fsm i_cmd_fsm (
        .clk_sys    (clk_sys),
        .rstb       (rstb),
        .op_empty   (op_empty),
        .op_data    (op_rdata),
        .word_empty (word_empty),
        .word_data  (word_rdata),
        .done       (done),
        .op_pop     (op_pop),
        .word_pop   (word_pop),
        .angle      (angle),
        .ready      (ready),
        .smp        (i_smp.cmd)
    );

    pi_current_ctrl #(.Q_BITS(Q_BITS)) i_pi_ctrl (
        .clk_sys (clk_sys),
        .rstb    (rstb),
        .smp     (i_smp.ctrl),
        .duty    (duty),
        .done    (done)
    );

    pwm_timer i_pwm_timer (
        .clk_sys (clk_sys),
        .rstb    (rstb),
        .period  (i_smp.period),
        .duty    (duty),
        .angle   (angle),
        .load    (done),
        .pwm_a   (pwm_a),
        .pwm_b   (pwm_b),
        .pwm_c   (pwm_c)
    );

endmodule

`default_nettype wire

/* tb/foc_ctrl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module foc_ctrl_properties (
    input logic                clk_sys,
    input logic                rstb,
    input logic                start,
    input logic                done,
    input logic                pwm_a,
    input logic                pwm_b,
    input logic                pwm_c,
    input logic                ready,
    input foc_pkg::cmd_state_t fsm_state
);

    // Start is a single pulse and done follows two cycles later
    start_single_cycle: assert property (
        @(posedge clk_sys) disable iff (!rstb) start |=> !start ##1 done
    ) else $error("start not a single pulse followed by done after two cycles");

    // Only the selected phase may switch
    one_phase_active: assert property (
        @(posedge clk_sys) disable iff (!rstb) $onehot0({pwm_a, pwm_b, pwm_c})
    ) else $error("more than one pwm output high");

    // Ready is low exactly while a sample is in flight
    ready_in_idle: assert property (
        @(posedge clk_sys) disable iff (!rstb)
            ready == !(fsm_state inside {foc_pkg::SMP_MEAS, foc_pkg::SMP_TARGET,
                                         foc_pkg::SMP_ANGLE, foc_pkg::WAIT_CTRL})
    ) else $error("ready does not match the command FSM state");

endmodule

bind foc_ctrl_top foc_ctrl_properties i_foc_ctrl_properties (
    .clk_sys   (clk_sys),
    .rstb      (rstb),
    .start     (i_smp.start),
    .done      (done),
    .pwm_a     (pwm_a),
    .pwm_b     (pwm_b),
    .pwm_c     (pwm_c),
    .ready     (ready),
    .fsm_state (i_cmd_fsm.state)
);

`default_nettype wire

/* tb/foc_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module foc_ctrl_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int HALF         = 4;
    localparam int PERIOD       = 256;
    localparam int Q_BITS       = 8;
    localparam int NUM_FRAMES   = 18;
    localparam int NUM_CHECKS   = 14;
    localparam int FRAME_CYCLES = (8 + 3 * 16) * 2 * HALF + 8 * HALF;
    localparam int RUN_CYCLES   = NUM_FRAMES * FRAME_CYCLES + NUM_CHECKS * 3 * PERIOD + 1000;

    logic clk_sys = 1'b0;
    logic rstb;
    logic spi_sclk;
    logic spi_cs_n;
    logic spi_mosi;
    logic full_spi;
    logic pwm_a;
    logic pwm_b;
    logic pwm_c;
    logic ready;

    logic [31:0] lcg_state = 32'hea2a;
    int          model_kp;
    int          model_ki;
    int          model_period;
    longint      model_integ;
    int          model_duty;
    int          model_sel;

    foc_ctrl_top #(.Q_BITS(Q_BITS), .FIFO_DEPTH(8)) i_foc_ctrl_top (
        .clk_sys  (clk_sys),
        .rstb     (rstb),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .full_spi (full_spi),
        .pwm_a    (pwm_a),
        .pwm_b    (pwm_b),
        .pwm_c    (pwm_c),
        .ready    (ready)
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    ////////////////////
    // Reference model
    ////////////////////
    function automatic int rand_current();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:8] % 23'd4001) - 2000;
    endfunction

    function automatic longint sat16(input longint v);
        if (v > 64'sd32767) begin
            return 64'sd32767;
        end else if (v < -64'sd32768) begin
            return -64'sd32768;
        end
        return v;
    endfunction

    function automatic int expected_duty(input longint err, input longint integ);
        longint acc;
        acc = longint'(model_kp) * err + longint'(model_ki) * integ;
        acc = acc >>> Q_BITS;
        if (acc < 64'sd0) begin
            return 0;
        end else if (acc > longint'(model_period)) begin
            return model_period;
        end
        return int'(acc);
    endfunction

    // 0, 1, 2 for phase a, b, c
    function automatic int phase_of(input int angle);
        if (angle < 21845) begin
            return 0;
        end else if (angle < 43690) begin
            return 1;
        end
        return 2;
    endfunction

    ////////////////////
    // Helpers
    ////////////////////
    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk_sys);
    endtask

    task automatic end_in_failure();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        if (got !== expected) begin
            $display("FAILED at time %0t: %s = %0d, expected %0d", $time, name, got, expected);
            end_in_failure();
        end
    endtask

    // Mode 0, data changes while sclk is low
    task automatic shift_bits(input logic [15:0] value, input int nbits);
        for (int i = nbits - 1; i >= 0; i--) begin
            spi_mosi <= value[i];
            wait_clocks(HALF);
            spi_sclk <= 1'b1;
            wait_clocks(HALF);
            spi_sclk <= 1'b0;
        end
    endtask

    task automatic send_frame(input logic [7:0] op, input int nwords,
                              input logic [15:0] w0, input logic [15:0] w1,
                              input logic [15:0] w2);
        logic [15:0] words [3];
        words[0] = w0;
        words[1] = w1;
        words[2] = w2;
        @(posedge clk_sys);
        spi_cs_n <= 1'b0;
        wait_clocks(HALF);
        shift_bits({8'h00, op}, 8);
        for (int k = 0; k < nwords; k++) begin
            shift_bits(words[k], 16);
        end
        wait_clocks(HALF);
        spi_cs_n <= 1'b1;
        wait_clocks(2 * HALF);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk_sys);
        while (ready !== 1'b1) begin
            @(negedge clk_sys);
            n++;
            if (n > 2000) begin
                $display("ERROR: ready did not return high within 2000 cycles");
                end_in_failure();
            end
        end
    endtask

    task automatic send_gains(input int kp, input int ki, input int period);
        send_frame(8'h00, 3, 16'(kp), 16'(ki), 16'(period));
        model_kp     = kp;
        model_ki     = ki;
        model_period = period;
        model_integ  = 0;
        wait_ready();
    endtask

    task automatic send_sample(input int meas, input int target, input int angle);
        longint err;
        send_frame(8'hff, 3, 16'(meas), 16'(target), 16'(angle));
        err         = longint'(target) - longint'(meas);
        model_integ = sat16(model_integ + err);
        model_duty  = expected_duty(err, model_integ);
        model_sel   = phase_of(angle);
        wait_ready();
    endtask

    // New duty reaches the outputs at the next wrap
    task automatic check_pwm(input int sel, input int duty);
        int ca;
        int cb;
        int cc;
        ca = 0;
        cb = 0;
        cc = 0;
        wait_clocks(2 * model_period);
        repeat (model_period) begin
            @(negedge clk_sys);
            if (pwm_a) begin
                ca++;
            end
            if (pwm_b) begin
                cb++;
            end
            if (pwm_c) begin
                cc++;
            end
        end
        check_value("pwm_a high cycles", ca, (sel == 0) ? duty : 0);
        check_value("pwm_b high cycles", cb, (sel == 1) ? duty : 0);
        check_value("pwm_c high cycles", cc, (sel == 2) ? duty : 0);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_reset_state();
        @(negedge clk_sys);
        check_value("ready", int'(ready), 1);
        check_value("pwm_a", int'(pwm_a), 0);
        check_value("pwm_b", int'(pwm_b), 0);
        check_value("pwm_c", int'(pwm_c), 0);
        check_value("full_spi", int'(full_spi), 0);
    endtask

    task automatic test_gains_and_sample();
        send_gains(8, 2, PERIOD);
        send_sample(-300, 1200, 5000);
        check_pwm(model_sel, model_duty);
    endtask

    task automatic test_phase_select();
        send_sample(0, 800, 1000);
        check_pwm(0, model_duty);
        send_sample(0, 800, 30000);
        check_pwm(1, model_duty);
        send_sample(0, 800, 60000);
        check_pwm(2, model_duty);
    endtask

    task automatic test_clamping();
        send_gains(64, 0, PERIOD);
        send_sample(-10000, 10000, 100);
        check_pwm(0, PERIOD);
        send_sample(10000, -10000, 30000);
        check_pwm(1, 0);
    endtask

    task automatic test_integrator();
        send_gains(8, 4, PERIOD);
        repeat (5) begin
            send_sample(rand_current(), rand_current(), 1000);
            check_pwm(model_sel, model_duty);
        end
        // Fresh gains frame clears the integrator
        send_gains(8, 4, PERIOD);
        send_sample(rand_current(), rand_current(), 50000);
        check_pwm(model_sel, model_duty);
    endtask

    task automatic test_unknown_opcode();
        send_frame(8'h5a, 0, 16'h0000, 16'h0000, 16'h0000);
        @(negedge clk_sys);
        check_value("ready", int'(ready), 1);
        check_pwm(model_sel, model_duty);
        send_sample(-500, 700, 40000);
        check_pwm(model_sel, model_duty);
        check_value("full_spi", int'(full_spi), 0);
    endtask

    initial begin
        rstb     = 1'b0;
        spi_sclk = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        wait_clocks(3);
        rstb <= 1'b1;
        wait_clocks(2);
        test_reset_state();
        test_gains_and_sample();
        test_phase_select();
        test_clamping();
        test_integrator();
        test_unknown_opcode();
        $display("*** PASSED ***");
        $finish;
    end

    // Run limit from frame count and PWM measurement windows
    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        end_in_failure();
    end

endmodule

`default_nettype wire

/* foc_ctrl.f */
rtl/foc_pkg.sv
rtl/foc_sample_if.sv
rtl/spi_frame_rx.sv
rtl/sync_fifo.sv
rtl/foc_cmd_fsm.sv
rtl/pi_current_ctrl.sv
rtl/pwm_timer.sv
rtl/foc_ctrl_top.sv
tb/foc_ctrl_properties.sv
tb/foc_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench; exit status is nonzero on failure
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -j 0 \
    --top-module foc_ctrl_tb -f foc_ctrl.f -o foc_ctrl_sim && \
./obj_dir/foc_ctrl_sim || exit 1
